// File: Makefile
VERILATOR ?= verilator
FLIST     ?= flist.f
TOP       ?= tb_rule_scanner
LINT_TOP  ?= rule_scanner_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '** PASS **' $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) +incdir+logic \
		logic/scan_pkg.sv logic/literal_dfa.sv logic/rule_context.sv \
		logic/stream_table.sv logic/packet_sequencer.sv logic/rule_scanner_top.sv \
		--top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: flist.f
+incdir+logic
logic/scan_pkg.sv
logic/literal_dfa.sv
logic/rule_context.sv
logic/stream_table.sv
logic/packet_sequencer.sv
logic/rule_scanner_top.sv
tb/tb_rule_scanner.sv

// File: logic/literal_dfa.sv
`timescale 1ns/1ps
`include "scan_consts.svh"

module literal_dfa import scan_pkg::*; #(
  parameter logic [31:0] PATTERN = 32'h0
) (
  input  logic       clk,
  input  logic       rst_n,
  input  byte_t      char,
  input  logic       char_vld,
  input  dfa_state_t state_in,
  input  logic       state_in_vld,
  output dfa_state_t state_out,
  output logic       accept
);

  // History holds one byte less than the pattern
  localparam int HIST_W = (`SCAN_PAT_LEN - 1) * 8;
  localparam logic [1:0] FILL_MAX = 2'(`SCAN_PAT_LEN - 1);

  logic [HIST_W-1:0] hist;
  logic [1:0]        fill;
  logic [HIST_W-1:0] hist_next;
  logic [1:0]        fill_next;
  logic              hit;

  // Current history and fill count from the state register
  assign hist = state_out[HIST_W+1:2];
  assign fill = state_out[1:0];

  // Oldest byte drops off the top, new byte enters at the bottom
  assign hist_next = {hist[HIST_W-9:0], char};

  // Fill count saturates once the history is full
  assign fill_next = (fill == FILL_MAX) ? FILL_MAX : fill + 2'd1;

  // Full history plus this byte spells the pattern
  assign hit = (fill == FILL_MAX) && ({hist, char} == PATTERN);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_out <= '0;
      accept    <= 1'b0;
    end
    else if (state_in_vld)
    begin
      // Restored or fresh state replaces whatever was here
      state_out <= state_in;
      accept    <= 1'b0;
    end
    else if (char_vld)
    begin
      state_out <= {hist_next, fill_next};
      accept    <= hit;
    end
    else
    begin
      // accept is a one-cycle pulse per matching byte
      accept <= 1'b0;
    end
  end

endmodule

// File: logic/packet_sequencer.sv
`timescale 1ns/1ps
`include "scan_consts.svh"

module packet_sequencer import scan_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  req,
  output logic  ack,
  input  byte_t data,
  input  logic  sop,
  input  logic  eop,
  output byte_t char,
  output logic  char_vld,
  output logic  load_state,
  output logic  pkt_end
);

  seq_state_t state;

  // Counts the wait cycles between the last char and pkt_end
  logic [1:0] drain_cnt;

  // Byte is held here while the rules consume it
  always_ff @(posedge clk)
  begin
    if (state == IDLE && req)
      char <= data;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state      <= IDLE;
      ack        <= 1'b0;
      char_vld   <= 1'b0;
      load_state <= 1'b0;
      pkt_end    <= 1'b0;
      drain_cnt  <= 2'd0;
    end
    else
    begin
      case (state)
        IDLE:
        begin
          if (req)
          begin
            // First byte of a packet restores the stream state first
            if (sop)
            begin
              load_state <= 1'b1;
              state      <= LOAD;
            end
            else
            begin
              char_vld <= 1'b1;
              state    <= CHAR;
            end
          end
        end
        LOAD:
        begin
          load_state <= 1'b0;
          state      <= LOAD_WAIT;
        end
        LOAD_WAIT:
        begin
          // Restored state reaches the DFA before this char does
          char_vld <= 1'b1;
          state    <= CHAR;
        end
        CHAR:
        begin
          char_vld  <= 1'b0;
          drain_cnt <= 2'd0;
          if (eop)
          begin
            state <= DRAIN;
          end
          else
          begin
            ack   <= 1'b1;
            state <= ACK;
          end
        end
        DRAIN:
        begin
          // Let accept_r and state_out_r of the last char settle
          drain_cnt <= drain_cnt + 2'd1;
          if (drain_cnt == 2'd2)
          begin
            pkt_end <= 1'b1;
            state   <= FINAL;
          end
        end
        FINAL:
        begin
          // Counts are final now
          pkt_end <= 1'b0;
          ack     <= 1'b1;
          state   <= ACK;
        end
        ACK:
        begin
          if (!req)
          begin
            ack   <= 1'b0;
            state <= IDLE;
          end
        end
        default:
        begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

// File: logic/rule_context.sv
`timescale 1ns/1ps
`include "scan_consts.svh"

module rule_context import scan_pkg::*; #(
  parameter logic [31:0] PATTERN = 32'h0
) (
  input  logic       clk,
  input  logic       rst_n,
  input  byte_t      char,
  input  logic       char_vld,
  input  logic       load_state,
  input  logic       new_stream,
  input  logic       pkt_end,
  input  logic       enable,
  input  stream_id_t stream_id,
  output count_t     count,
  output logic       fired
);

  localparam int DEPTH = 1 << `SCAN_STREAM_W;

  // Saved recogniser state, one entry per stream
  dfa_state_t state_mem [DEPTH];

  // State fetched at packet start
  dfa_state_t state_in;
  logic       state_in_vld;

  // Registered recogniser inputs
  byte_t      char_r;
  logic       char_vld_r;
  dfa_state_t state_in_r;
  logic       state_in_vld_r;

  // Recogniser outputs, raw and registered
  dfa_state_t state_out;
  logic       accept;
  dfa_state_t state_out_r;
  logic       accept_r;

  // Fetch saved state on load, fresh streams start empty
  always_ff @(posedge clk)
  begin
    if (load_state)
    begin
      state_in <= new_stream ? '0 : state_mem[stream_id];
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_in_vld <= 1'b0;
    end
    else
    begin
      state_in_vld <= load_state;
    end
  end

  // Strobes of the recogniser boundary
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      char_vld_r     <= 1'b0;
      state_in_vld_r <= 1'b0;
      accept_r       <= 1'b0;
    end
    else
    begin
      char_vld_r     <= char_vld;
      state_in_vld_r <= state_in_vld;
      accept_r       <= accept;
    end
  end

  // Data of the recogniser boundary
  always_ff @(posedge clk)
  begin
    char_r      <= char;
    state_in_r  <= state_in;
    state_out_r <= state_out;
  end

  // Match flag and packet count
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      count <= '0;
      fired <= 1'b0;
    end
    else
    begin
      // New packet starts unmatched
      if (load_state)
        fired <= 1'b0;
      // Any registered accept marks the packet as matched
      if (accept_r)
        fired <= 1'b1;
      if (pkt_end)
      begin
        if (enable)
          count <= count + count_t'(fired);
        else
          fired <= 1'b0;
      end
    end
  end

  // Write back the final history of an enabled rule
  always_ff @(posedge clk)
  begin
    if (pkt_end && enable)
      state_mem[stream_id] <= state_out_r;
  end

  literal_dfa #(
    .PATTERN (PATTERN)
  ) i_dfa (
    .clk          (clk),
    .rst_n        (rst_n),
    .char         (char_r),
    .char_vld     (char_vld_r),
    .state_in     (state_in_r),
    .state_in_vld (state_in_vld_r),
    .state_out    (state_out),
    .accept       (accept)
  );

endmodule

// File: logic/rule_scanner_top.sv
`timescale 1ns/1ps
`include "scan_consts.svh"

module rule_scanner_top import scan_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       req,
  output logic       ack,
  input  byte_t      data,
  input  logic       sop,
  input  logic       eop,
  input  stream_id_t stream_id,
  input  rule_mask_t rule_enable,
  output rule_mask_t fired,
  output count_t     count_0,
  output count_t     count_1,
  output count_t     count_2,
  output count_t     count_3
);

  // Pattern of each rule context
  localparam logic [31:0] PATTERNS [`SCAN_NUM_RULES] = '{
    `SCAN_PATTERN_0,
    `SCAN_PATTERN_1,
    `SCAN_PATTERN_2,
    `SCAN_PATTERN_3
  };

  byte_t  char;
  logic   char_vld;
  logic   load_state;
  logic   pkt_end;
  logic   new_stream;
  count_t counts [`SCAN_NUM_RULES];

  packet_sequencer i_seq (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .ack        (ack),
    .data       (data),
    .sop        (sop),
    .eop        (eop),
    .char       (char),
    .char_vld   (char_vld),
    .load_state (load_state),
    .pkt_end    (pkt_end)
  );

  stream_table i_streams (
    .clk        (clk),
    .rst_n      (rst_n),
    .stream_id  (stream_id),
    .load_state (load_state),
    .new_stream (new_stream)
  );

  // All rules see the same bytes and strobes
  for (genvar g = 0; g < `SCAN_NUM_RULES; g++)
  begin : g_rule
    rule_context #(
      .PATTERN (PATTERNS[g])
    ) i_rule (
      .clk        (clk),
      .rst_n      (rst_n),
      .char       (char),
      .char_vld   (char_vld),
      .load_state (load_state),
      .new_stream (new_stream),
      .pkt_end    (pkt_end),
      .enable     (rule_enable[g]),
      .stream_id  (stream_id),
      .count      (counts[g]),
      .fired      (fired[g])
    );
  end

  assign count_0 = counts[0];
  assign count_1 = counts[1];
  assign count_2 = counts[2];
  assign count_3 = counts[3];

endmodule

// File: logic/scan_consts.svh
`ifndef SCAN_CONSTS_SVH
`define SCAN_CONSTS_SVH

// Number of independent rule contexts
`define SCAN_NUM_RULES 4

// Literal pattern length in bytes
`define SCAN_PAT_LEN 4

// Stream id width, 64 streams
`define SCAN_STREAM_W 6

// Per-rule match counter width
`define SCAN_COUNT_W 16

// Rule patterns, first byte in the high bits
// "root"
`define SCAN_PATTERN_0 32'h726f_6f74
// "exec"
`define SCAN_PATTERN_1 32'h6578_6563
// "/bin"
`define SCAN_PATTERN_2 32'h2f62_696e
// "cmd."
`define SCAN_PATTERN_3 32'h636d_642e

`endif

// File: logic/scan_pkg.sv
`include "scan_consts.svh"

package scan_pkg;

  // One packet byte
  typedef logic [7:0] byte_t;

  // Stream identifier carried with every byte
  typedef logic [`SCAN_STREAM_W-1:0] stream_id_t;

  // Per-rule packet match count
  typedef logic [`SCAN_COUNT_W-1:0] count_t;

  // Recogniser state
  // Upper bits hold the last three bytes, oldest on top
  // Low 2 bits count how many of them are valid
  // All zeros is the start state
  typedef logic [(`SCAN_PAT_LEN-1)*8+1:0] dfa_state_t;

  // One bit per rule, enables and fired flags
  typedef logic [`SCAN_NUM_RULES-1:0] rule_mask_t;

  // Byte sequencer states
  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    LOAD_WAIT,
    CHAR,
    DRAIN,
    FINAL,
    ACK
  } seq_state_t;

endpackage

// File: logic/stream_table.sv
`timescale 1ns/1ps
`include "scan_consts.svh"

module stream_table import scan_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  stream_id_t stream_id,
  input  logic       load_state,
  output logic       new_stream
);

  localparam int NUM_STREAMS = 1 << `SCAN_STREAM_W;

  // One bit per stream id, set once the stream has started a packet
  logic [NUM_STREAMS-1:0] seen;

  // The state memories in the rule contexts hold garbage
  // until a stream has written its first entry
  // A clear bit here makes every rule start from the empty state

  // Answer straight from the map for the id on the link
  assign new_stream = ~seen[stream_id];

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      // All streams unknown after reset
      seen <= '0;
    end
    else if (load_state)
    begin
      // Rule contexts sample new_stream in this same cycle
      // so the mark only shows from the next packet on
      seen[stream_id] <= 1'b1;
    end
  end

endmodule

// File: tb/tb_rule_scanner.sv
`timescale 1ns/1ps
`include "scan_consts.svh"

module tb_rule_scanner import scan_pkg::*; ;

  localparam int NUM_RANDOM_PKTS   = 300;
  localparam int NUM_DIRECTED_PKTS = 8;
  localparam int MAX_PKT_LEN       = 12;
  // Worst byte is a sop+eop byte, about 13 cycles with the handshake and the req hold
  localparam int CYCLES_PER_BYTE   = 16;
  localparam int TIMEOUT_CYCLES    =
    (NUM_RANDOM_PKTS + NUM_DIRECTED_PKTS) * MAX_PKT_LEN * CYCLES_PER_BYTE + 50;
  localparam int NUM_STREAMS       = 1 << `SCAN_STREAM_W;

  logic       clk;
  logic       rst_n;
  logic       req;
  logic       ack;
  byte_t      data;
  logic       sop;
  logic       eop;
  stream_id_t stream_id;
  rule_mask_t rule_enable;
  rule_mask_t fired;
  count_t     count_0;
  count_t     count_1;
  count_t     count_2;
  count_t     count_3;

  // Reference model state
  logic [31:0] patterns [`SCAN_NUM_RULES];
  byte_t       hist_b [`SCAN_NUM_RULES][NUM_STREAMS][3];
  int          hist_n [`SCAN_NUM_RULES][NUM_STREAMS];
  count_t      exp_count [`SCAN_NUM_RULES];
  logic        seen_map [NUM_STREAMS];
  byte_t       pkt_q [$];
  byte_t       seq_q [$];

  int count_errs = 0;
  int fired_errs = 0;
  int hs_errs    = 0;
  int cycles     = 0;

  logic ack_prev = 1'b0;
  logic req_prev = 1'b0;

  rule_scanner_top i_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (req),
    .ack         (ack),
    .data        (data),
    .sop         (sop),
    .eop         (eop),
    .stream_id   (stream_id),
    .rule_enable (rule_enable),
    .fired       (fired),
    .count_0     (count_0),
    .count_1     (count_1),
    .count_2     (count_2),
    .count_3     (count_3)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Handshake watch, ack as it was during the previous cycle
  always @(posedge clk)
  begin
    if (rst_n && ack && !ack_prev && !req_prev)
    begin
      hs_errs++;
      $display("Handshake error at %0t: ack rose while req was low", $time);
    end
    if (rst_n && !ack && ack_prev && req_prev)
    begin
      hs_errs++;
      $display("Handshake error at %0t: ack fell while req was still high", $time);
    end
    ack_prev <= ack;
    req_prev <= req;
  end

  // Stuck handshake ends the run here
  initial
  begin
    while (cycles < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles: the byte handshake stopped making progress", cycles);
    $display("** FAIL **");
    $finish;
  end

  task automatic check_count(input int rule, input count_t got, input count_t exp);
    if (got !== exp)
    begin
      count_errs++;
      $display("Fail %0t: rule %0d count is %0d, expected %0d", $time, rule, got, exp);
    end
  endtask

  task automatic check_fired(input rule_mask_t got, input rule_mask_t exp);
    if (got !== exp)
    begin
      fired_errs++;
      $display("Fail %0t: fired is %b, expected %b", $time, got, exp);
    end
  endtask

  function automatic count_t dut_count(input int rule);
    case (rule)
      0: return count_0;
      1: return count_1;
      2: return count_2;
      default: return count_3;
    endcase
  endfunction

  // Pattern search over saved history plus packet
  // Only windows ending inside the packet count as a match
  task automatic model_packet(input stream_id_t id, input rule_mask_t en,
                              output rule_mask_t hits);
    int  n;
    int  keep;
    logic hit;
    for (int r = 0; r < `SCAN_NUM_RULES; r++)
    begin
      seq_q.delete();
      // First-seen stream starts from an empty history
      n = seen_map[id] ? hist_n[r][id] : 0;
      for (int i = 0; i < n; i++)
        seq_q.push_back(hist_b[r][id][i]);
      foreach (pkt_q[i])
        seq_q.push_back(pkt_q[i]);
      hit = 1'b0;
      for (int i = 0; i + 3 < seq_q.size(); i++)
      begin
        if (i + 3 >= n &&
            {seq_q[i], seq_q[i+1], seq_q[i+2], seq_q[i+3]} == patterns[r])
          hit = 1'b1;
      end
      hits[r] = hit;
      // Disabled rule keeps its count and old history
      if (en[r])
      begin
        exp_count[r] = exp_count[r] + count_t'(hit);
        keep = (seq_q.size() < 3) ? seq_q.size() : 3;
        for (int j = 0; j < keep; j++)
          hist_b[r][id][j] = seq_q[seq_q.size() - keep + j];
        hist_n[r][id] = keep;
      end
    end
    seen_map[id] = 1'b1;
  endtask

  // One byte over the four-phase link
  task automatic drive_byte(input byte_t b, input logic s, input logic e,
                            input stream_id_t id, input rule_mask_t en);
    rule_mask_t hits;
    @(negedge clk);
    data        = b;
    sop         = s;
    eop         = e;
    stream_id   = id;
    rule_enable = en;
    req         = 1'b1;
    @(negedge clk);
    while (!ack)
      @(negedge clk);
    // Counts are final once ack is up on the eop byte
    if (e)
      model_packet(id, en, hits);
    for (int r = 0; r < `SCAN_NUM_RULES; r++)
      check_count(r, dut_count(r), exp_count[r]);
    if (e)
      check_fired(fired, hits & en);
    // Source may keep req up for a while after ack
    repeat ($urandom_range(2, 0))
      @(negedge clk);
    req = 1'b0;
    @(negedge clk);
    while (ack)
      @(negedge clk);
  endtask

  task automatic send_packet(input stream_id_t id, input rule_mask_t en);
    foreach (pkt_q[i])
      drive_byte(pkt_q[i], i == 0, i == pkt_q.size() - 1, id, en);
  endtask

  task automatic send_string(input stream_id_t id, input rule_mask_t en, input string s);
    pkt_q.delete();
    for (int i = 0; i < s.len(); i++)
      pkt_q.push_back(byte_t'(s[i]));
    send_packet(id, en);
  endtask

  // Mostly pattern characters, now and then any byte
  function automatic byte_t pick_byte();
    logic [31:0] p;
    int          k;
    if ($urandom_range(7, 0) == 0)
      return byte_t'($urandom);
    p = patterns[$urandom_range(`SCAN_NUM_RULES - 1, 0)];
    k = $urandom_range(3, 0);
    return p[8*(3-k) +: 8];
  endfunction

  // Pieces of loose bytes, whole patterns and pattern tails
  task automatic build_random_packet(input int len);
    logic [31:0] p;
    int          start;
    pkt_q.delete();
    while (pkt_q.size() < len)
    begin
      p     = patterns[$urandom_range(`SCAN_NUM_RULES - 1, 0)];
      start = $urandom_range(3, 0);
      case ($urandom_range(3, 0))
        0, 1: pkt_q.push_back(pick_byte());
        2:
        begin
          for (int k = 0; k < 4 && pkt_q.size() < len; k++)
            pkt_q.push_back(p[8*(3-k) +: 8]);
        end
        default:
        begin
          for (int k = start; k < 4 && pkt_q.size() < len; k++)
            pkt_q.push_back(p[8*(3-k) +: 8]);
        end
      endcase
    end
  endtask

  initial
  begin
    stream_id_t id;
    rule_mask_t en;
    void'($urandom(32'h5373f9fb));
    patterns[0] = `SCAN_PATTERN_0;
    patterns[1] = `SCAN_PATTERN_1;
    patterns[2] = `SCAN_PATTERN_2;
    patterns[3] = `SCAN_PATTERN_3;
    foreach (exp_count[r])
      exp_count[r] = '0;
    foreach (seen_map[s])
      seen_map[s] = 1'b0;
    foreach (hist_n[r, s])
      hist_n[r][s] = 0;
    rst_n       = 1'b0;
    req         = 1'b0;
    data        = '0;
    sop         = 1'b0;
    eop         = 1'b0;
    stream_id   = '0;
    rule_enable = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    if (ack !== 1'b0)
    begin
      hs_errs++;
      $display("Handshake error at %0t: ack is not low after reset", $time);
    end

    // Split pattern, fresh stream isolation, repeated matches
    send_string(1, 4'b1111, "xro");
    send_string(2, 4'b1111, "ot");
    send_string(1, 4'b1111, "ot");
    send_string(3, 4'b1111, "execexec/bin");
    // Rule 3 off for the middle packet, its history stays "xcm"
    send_string(4, 4'b1111, "xcm");
    send_string(4, 4'b0111, "d");
    send_string(4, 4'b1111, ".");
    send_string(5, 4'b1111, "r");

    // Random packets over interleaved streams
    for (int p = 0; p < NUM_RANDOM_PKTS; p++)
    begin
      if ($urandom_range(9, 0) == 0)
        id = stream_id_t'($urandom_range(NUM_STREAMS - 1, 0));
      else
        id = stream_id_t'($urandom_range(5, 0));
      // Whole first packet of a stream fills every rule's saved entry
      if (!seen_map[id])
        en = '1;
      else
        en = rule_mask_t'($urandom | $urandom);
      build_random_packet($urandom_range(MAX_PKT_LEN, 1));
      send_packet(id, en);
    end

    repeat (4) @(negedge clk);
    $display("Errors: count %0d, fired %0d, handshake %0d", count_errs, fired_errs, hs_errs);
    if (count_errs + fired_errs + hs_errs == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule
